// File: alu.sv
`include "cpu_consts.svh"

module alu
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        capture,
    input  opcode_t     opcode,
    input  word_t       operand_a,
    input  word_t       operand_b,
    input  logic [15:0] value,
    input  logic        highlow,
    output word_t       result,
    output logic        flag_out
);

    word_t next_result;
    logic  next_flag;
    logic  less_than;

    // unsigned compare, shared by cmplt result and flag
    assign less_than = operand_a < operand_b;

    always_comb
    begin
        case (opcode)
            `OP_ADD:
            begin
                next_result = operand_a + operand_b;
            end
            `OP_SUB:
            begin
                next_result = operand_a - operand_b;
            end
            `OP_AND:
            begin
                next_result = operand_a & operand_b;
            end
            `OP_OR:
            begin
                next_result = operand_a | operand_b;
            end
            `OP_XOR:
            begin
                next_result = operand_a ^ operand_b;
            end
            `OP_SHL:
            begin
                next_result = operand_a << operand_b[4:0];
            end
            `OP_CMPLT:
            begin
                next_result = word_t'(less_than);
            end
            `OP_LDI:
            begin
                // highlow picks the half that gets the immediate
                if (highlow)
                begin
                    next_result = {value, 16'h0000};
                end
                else
                begin
                    next_result = {16'h0000, value};
                end
            end
            default:
            begin
                next_result = '0;
            end
        endcase
    end

    // compare sets the flag from its bit, the rest flag a zero result
    assign next_flag = (opcode == `OP_CMPLT) ? less_than : (next_result == '0);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            result   <= '0;
            flag_out <= 1'b0;
        end
        else if (capture)
        begin
            result   <= next_result;
            flag_out <= next_flag;
        end
    end

endmodule

// File: cpu.sv
`include "cpu_consts.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  word_t mem_rdata,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_write,
    output logic  halted
);

    logic        capture;
    logic        bank_write;
    opcode_t     opcode;
    reg_idx_t    ra;
    reg_idx_t    rb;
    reg_idx_t    rd;
    logic [15:0] value;
    logic        highlow;
    word_t       operand_a;
    word_t       operand_b;
    word_t       result;
    logic        flag_out;
    logic        flag_a;

    // store data comes from register ra
    assign mem_wdata = operand_a;

    cpu_control control (
        .clock      (clock),
        .rst_n      (rst_n),
        .mem_rdata  (mem_rdata),
        .flag_a     (flag_a),
        .mem_addr   (mem_addr),
        .mem_write  (mem_write),
        .halted     (halted),
        .capture    (capture),
        .bank_write (bank_write),
        .opcode     (opcode),
        .ra         (ra),
        .rb         (rb),
        .rd         (rd),
        .value      (value),
        .highlow    (highlow)
    );

    alu alu_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .capture   (capture),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .value     (value),
        .highlow   (highlow),
        .result    (result),
        .flag_out  (flag_out)
    );

    reg_bank #(.payload_t(word_t)) word_bank (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_en   (bank_write),
        .write_idx  (rd),
        .write_data (result),
        .read_idx_a (ra),
        .read_idx_b (rb),
        .read_a     (operand_a),
        .read_b     (operand_b)
    );

    // flags share rd with the words, only port a is read
    reg_bank #(.payload_t(logic)) flag_bank (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_en   (bank_write),
        .write_idx  (rd),
        .write_data (flag_out),
        .read_idx_a (ra),
        .read_idx_b (rb),
        .read_a     (flag_a),
        .read_b     ()
    );

endmodule

// File: cpu_checker.sv
module cpu_checker (
    input logic clock,
    input logic rst_n,
    input logic mem_write,
    input logic halted
);

    int violations = 0;

    no_store_while_halted: assert property (@(posedge clock) disable iff (!rst_n)
        !(mem_write && halted))
    else
    begin
        violations++;
        $error("mem_write high while halted");
    end

    // a store strobe lasts exactly one execute cycle
    single_cycle_store: assert property (@(posedge clock) disable iff (!rst_n)
        mem_write |=> !mem_write)
    else
    begin
        violations++;
        $error("mem_write high for two cycles in a row");
    end

    halt_is_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
    else
    begin
        violations++;
        $error("halted fell while out of reset");
    end

    quiet_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> (!mem_write && !halted))
    else
    begin
        violations++;
        $error("mem_write or halted high in the first cycle after reset");
    end

endmodule

bind cpu cpu_checker protocol_chk (
    .clock     (clock),
    .rst_n     (rst_n),
    .mem_write (mem_write),
    .halted    (halted)
);

// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and address width
`define CPU_WORD_W 32

// general registers and flags share one index space
`define CPU_NREGS 8

// instruction word fields
`define CPU_OP_HI  5
`define CPU_OP_LO  0
`define CPU_RA_HI  8
`define CPU_RA_LO  6
`define CPU_RB_HI  11
`define CPU_RB_LO  9
`define CPU_RD_HI  14
`define CPU_RD_LO  12
`define CPU_HL_BIT 15
`define CPU_VAL_HI 31
`define CPU_VAL_LO 16

// opcodes, anything not listed runs as a nop
`define OP_NOP   6'd0
`define OP_ADD   6'd1
`define OP_SUB   6'd2
`define OP_AND   6'd3
`define OP_OR    6'd4
`define OP_XOR   6'd5
`define OP_LDI   6'd6
`define OP_STORE 6'd7
`define OP_CMPLT 6'd8
`define OP_BRF   6'd9
`define OP_SHL   6'd10
`define OP_HALT  6'd63

`endif

// File: cpu_control.sv
`include "cpu_consts.svh"

module cpu_control
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  word_t       mem_rdata,
    input  logic        flag_a,
    output word_t       mem_addr,
    output logic        mem_write,
    output logic        halted,
    output logic        capture,
    output logic        bank_write,
    output opcode_t     opcode,
    output reg_idx_t    ra,
    output reg_idx_t    rb,
    output reg_idx_t    rd,
    output logic [15:0] value,
    output logic        highlow
);

    cpu_state_t state;
    word_t      pc;
    word_t      ir;
    logic       is_store;
    logic       is_write_class;
    logic       take_branch;
    word_t      value_ext;

    // instruction fields
    assign opcode  = ir[`CPU_OP_HI:`CPU_OP_LO];
    assign ra      = ir[`CPU_RA_HI:`CPU_RA_LO];
    assign rb      = ir[`CPU_RB_HI:`CPU_RB_LO];
    assign rd      = ir[`CPU_RD_HI:`CPU_RD_LO];
    assign highlow = ir[`CPU_HL_BIT];
    assign value   = ir[`CPU_VAL_HI:`CPU_VAL_LO];

    assign value_ext = word_t'(value);

    assign is_store = (opcode == `OP_STORE);

    always_comb
    begin
        case (opcode)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR,
            `OP_SHL, `OP_CMPLT, `OP_LDI:
            begin
                is_write_class = 1'b1;
            end
            default:
            begin
                is_write_class = 1'b0;
            end
        endcase
    end

    // flag_a is indexed by ra, read before this cycle's bank write
    assign take_branch = (opcode == `OP_BRF) && flag_a;

    assign capture    = (state == ST_EXECUTE);
    assign mem_write  = (state == ST_EXECUTE) && is_store;
    assign bank_write = (state == ST_WRITEBACK) && is_write_class;
    assign halted     = (state == ST_HALTED);

    // store address only in its execute cycle, pc otherwise
    assign mem_addr = mem_write ? value_ext : pc;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state <= ST_FETCH;
            pc    <= '0;
        end
        else
        begin
            case (state)
                ST_FETCH:
                begin
                    state <= ST_EXECUTE;
                end
                ST_EXECUTE:
                begin
                    if (opcode == `OP_HALT)
                    begin
                        state <= ST_HALTED;
                    end
                    else
                    begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK:
                begin
                    state <= ST_FETCH;
                    pc    <= take_branch ? value_ext : pc + 1'b1;
                end
                default:
                begin
                    state <= ST_HALTED;
                end
            endcase
        end
    end

    // instruction word is taken straight off the bus at the end of fetch
    always_ff @(posedge clock)
    begin
        if (state == ST_FETCH)
        begin
            ir <= mem_rdata;
        end
    end

endmodule

// File: cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    // one data word, also used for addresses
    typedef logic [`CPU_WORD_W-1:0] word_t;

    // selects one of the registers or flags
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // low field of the instruction word
    typedef logic [`CPU_OP_HI-`CPU_OP_LO:0] opcode_t;

    // instruction sequence of the controller
    typedef enum logic [1:0] {
        ST_FETCH     = 2'd0,
        ST_EXECUTE   = 2'd1,
        ST_WRITEBACK = 2'd2,
        ST_HALTED    = 2'd3
    } cpu_state_t;

endpackage

// File: cpu_scoreboard.sv
`include "cpu_consts.svh"

module cpu_scoreboard
    import cpu_pkg::*;
#(
    parameter int DEPTH = 128
)
(
    input  logic  clock,
    input  logic  rst_n,
    input  word_t mem_addr,
    input  word_t mem_wdata,
    input  logic  mem_write,
    input  logic  halted,
    input  word_t exp_addr [DEPTH],
    input  word_t exp_data [DEPTH],
    input  int    exp_stores,
    input  int    exp_instr,
    output logic  done,
    output int    store_errors,
    output int    halt_errors
);

    // cycle 0 ends at the first edge that sees rst_n high
    int cycle;
    int stores_seen;

    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            cycle        = 0;
            stores_seen  = 0;
            done         = 1'b0;
            store_errors = 0;
            halt_errors  = 0;
        end
        else
        begin
            if (mem_write)
            begin
                if (done)
                begin
                    $display("store seen at time %0t after the processor halted", $time);
                    store_errors++;
                end
                else if (stores_seen >= exp_stores)
                begin
                    $display("store to %h at time %0t was not expected", mem_addr, $time);
                    store_errors++;
                end
                else if (mem_addr !== exp_addr[stores_seen] ||
                         mem_wdata !== exp_data[stores_seen])
                begin
                    $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, stores_seen, mem_wdata, mem_addr,
                             exp_data[stores_seen], exp_addr[stores_seen]);
                    store_errors++;
                end
                stores_seen++;
            end

            if (halted && !done)
            begin
                done = 1'b1;
                if (cycle != 3 * exp_instr + 2)
                begin
                    $display("** Error at %0t: halted rose in cycle %0d, expected cycle %0d",
                             $time, cycle, 3 * exp_instr + 2);
                    halt_errors++;
                end
                if (stores_seen != exp_stores)
                begin
                    $display("** Error at %0t: %0d stores before halt, expected %0d",
                             $time, stores_seen, exp_stores);
                    halt_errors++;
                end
            end
            cycle++;
        end
    end

endmodule

// File: cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb
    import cpu_pkg::*;
;

    localparam int STORE_DEPTH   = 128;
    localparam int MAX_INSTR     = 200;
    localparam int WATCHDOG_TIME = (16 + 3 * MAX_INSTR + 20) * 40;

    logic  clock;
    logic  rst_n;
    word_t mem_rdata;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_write;
    logic  halted;

    word_t prog [64];
    int    fill_pos;
    word_t exp_addr [STORE_DEPTH];
    word_t exp_data [STORE_DEPTH];
    int    exp_stores;
    int    exp_instr;
    logic  sb_done;
    int    store_errors;
    int    halt_errors;

    // combinational memory where anything past the program reads as halt
    assign mem_rdata = (mem_addr < 32'd64) ? prog[mem_addr[5:0]] : {26'd0, `OP_HALT};

    cpu uut (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (mem_write),
        .halted    (halted)
    );

    cpu_scoreboard #(.DEPTH(STORE_DEPTH)) scoreboard (
        .clock        (clock),
        .rst_n        (rst_n),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_write    (mem_write),
        .halted       (halted),
        .exp_addr     (exp_addr),
        .exp_data     (exp_data),
        .exp_stores   (exp_stores),
        .exp_instr    (exp_instr),
        .done         (sb_done),
        .store_errors (store_errors),
        .halt_errors  (halt_errors)
    );

    function automatic word_t encode_instr(opcode_t op, reg_idx_t ra, reg_idx_t rb,
                                           reg_idx_t rd, logic hl, logic [15:0] val);
        return {val, hl, rd, rb, ra, op};
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'($urandom_range(5, 1));
    endfunction

    function automatic logic [15:0] rand_half();
        return 16'($urandom);
    endfunction

    function automatic opcode_t arith_op(int i);
        case (i)
            0: return `OP_ADD;
            1: return `OP_SUB;
            2: return `OP_AND;
            3: return `OP_XOR;
            default: return `OP_SHL;
        endcase
    endfunction

    task automatic put_instr(word_t w);
        prog[fill_pos] = w;
        fill_pos++;
    endtask

    task automatic build_program();
        reg_idx_t r;
        int       top;
        int       count;
        for (int i = 0; i < 64; i++)
        begin
            prog[i] = encode_instr(`OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0000);
        end
        fill_pos = 0;

        // both halves loaded then joined by or and stored
        put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, 3'd1, 1'b1, rand_half()));
        put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, 3'd2, 1'b0, rand_half()));
        put_instr(encode_instr(`OP_OR, 3'd1, 3'd2, 3'd3, 1'b0, 16'h0000));
        put_instr(encode_instr(`OP_STORE, 3'd3, 3'd0, 3'd0, 1'b0, rand_half()));

        for (int i = 0; i < 5; i++)
        begin
            r = pick_reg();
            put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, pick_reg(),
                                   1'($urandom_range(1, 0)), rand_half()));
            put_instr(encode_instr(arith_op(i), pick_reg(), pick_reg(), r, 1'b0, 16'h0000));
            put_instr(encode_instr(`OP_STORE, r, 3'd0, 3'd0, 1'b0, rand_half()));
        end

        // compare then branch over a store on the compare flag
        for (int i = 0; i < 2; i++)
        begin
            r = pick_reg();
            put_instr(encode_instr(`OP_CMPLT, pick_reg(), pick_reg(), r, 1'b0, 16'h0000));
            put_instr(encode_instr(`OP_BRF, r, 3'd0, 3'd0, 1'b0, 16'(fill_pos + 2)));
            put_instr(encode_instr(`OP_STORE, pick_reg(), 3'd0, 3'd0, 1'b0, rand_half()));
            put_instr(encode_instr(`OP_STORE, r, 3'd0, 3'd0, 1'b0, rand_half()));
        end

        // undefined opcodes aimed at a loaded register that must keep its value
        r = pick_reg();
        put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, r, 1'b1, rand_half() | 16'h8000));
        for (int i = 0; i < 2; i++)
        begin
            put_instr(encode_instr(opcode_t'($urandom_range(62, 11)), pick_reg(), pick_reg(),
                                   r, 1'($urandom_range(1, 0)), rand_half()));
        end
        put_instr(encode_instr(`OP_STORE, r, 3'd0, 3'd0, 1'b0, rand_half()));

        // counted loop where r7 holds zero so flag 7 gives an always-taken branch
        count = $urandom_range(5, 2);
        put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, 3'd7, 1'b0, 16'h0000));
        put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, 3'd6, 1'b0, 16'(count)));
        put_instr(encode_instr(`OP_LDI, 3'd0, 3'd0, 3'd5, 1'b0, 16'h0001));
        top = fill_pos;
        put_instr(encode_instr(`OP_STORE, 3'd6, 3'd0, 3'd0, 1'b0, rand_half()));
        put_instr(encode_instr(`OP_SUB, 3'd6, 3'd5, 3'd6, 1'b0, 16'h0000));
        put_instr(encode_instr(`OP_BRF, 3'd6, 3'd0, 3'd0, 1'b0, 16'(fill_pos + 2)));
        put_instr(encode_instr(`OP_BRF, 3'd7, 3'd0, 3'd0, 1'b0, 16'(top)));
        put_instr(encode_instr(`OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0000));
    endtask

    // runs the program by the instruction rules and returns the count before halt
    function automatic int model_run();
        word_t       regs [`CPU_NREGS];
        logic        flags [`CPU_NREGS];
        word_t       pc;
        word_t       ir;
        word_t       res;
        logic        wr;
        opcode_t     op;
        reg_idx_t    ra;
        reg_idx_t    rb;
        reg_idx_t    rd;
        logic [15:0] val;
        for (int i = 0; i < `CPU_NREGS; i++)
        begin
            regs[i]  = '0;
            flags[i] = 1'b0;
        end
        pc         = '0;
        exp_stores = 0;
        for (int steps = 0; steps < MAX_INSTR; steps++)
        begin
            ir  = (pc < 32'd64) ? prog[pc[5:0]] : {26'd0, `OP_HALT};
            op  = ir[5:0];
            ra  = ir[8:6];
            rb  = ir[11:9];
            rd  = ir[14:12];
            val = ir[31:16];
            if (op == `OP_HALT)
            begin
                return steps;
            end
            wr = 1'b1;
            case (op)
                `OP_ADD:   res = regs[ra] + regs[rb];
                `OP_SUB:   res = regs[ra] - regs[rb];
                `OP_AND:   res = regs[ra] & regs[rb];
                `OP_OR:    res = regs[ra] | regs[rb];
                `OP_XOR:   res = regs[ra] ^ regs[rb];
                `OP_SHL:   res = regs[ra] << regs[rb][4:0];
                `OP_CMPLT: res = (regs[ra] < regs[rb]) ? 32'd1 : 32'd0;
                `OP_LDI:   res = ir[15] ? {val, 16'h0000} : {16'h0000, val};
                default:
                begin
                    wr  = 1'b0;
                    res = '0;
                end
            endcase
            if (op == `OP_STORE)
            begin
                if (exp_stores < STORE_DEPTH)
                begin
                    exp_addr[exp_stores] = {16'h0000, val};
                    exp_data[exp_stores] = regs[ra];
                end
                exp_stores++;
            end
            if (wr)
            begin
                regs[rd]  = res;
                flags[rd] = (op == `OP_CMPLT) ? res[0] : (res == 32'd0);
            end
            pc = (op == `OP_BRF && flags[ra]) ? {16'h0000, val} : pc + 32'd1;
        end
        return -1;
    endfunction

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial
    begin
        int protocol_errors;
        void'($urandom(32'h3e6afc9f));
        rst_n = 1'b0;
        build_program();
        exp_instr = model_run();
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        wait (sb_done);
        // a few more cycles to catch stores after the halt
        repeat (8) @(posedge clock);
        protocol_errors = uut.protocol_chk.violations;
        $display("errors: store %0d, halt %0d, protocol %0d",
                 store_errors, halt_errors, protocol_errors);
        if (store_errors == 0 && halt_errors == 0 && protocol_errors == 0 && exp_instr >= 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("timeout: the processor did not halt within %0d instructions", MAX_INSTR);
        $display("Test failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
cpu_pkg.sv
reg_bank.sv
alu.sv
cpu_control.sv
cpu.sv
cpu_checker.sv
cpu_scoreboard.sv
cpu_tb.sv

// File: reg_bank.sv
`include "cpu_consts.svh"

module reg_bank
    import cpu_pkg::*;
#(
    parameter type payload_t = logic
)
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  payload_t write_data,
    input  reg_idx_t read_idx_a,
    input  reg_idx_t read_idx_b,
    output payload_t read_a,
    output payload_t read_b
);

    payload_t entries [`CPU_NREGS];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                entries[i] <= payload_t'(0);
            end
        end
        else if (write_en)
        begin
            entries[write_idx] <= write_data;
        end
    end

    // both reads see the old value during a write cycle
    assign read_a = entries[read_idx_a];
    assign read_b = entries[read_idx_b];

endmodule

// File: run.sh
#!/bin/sh
# compile the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f flist.f -o cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
output=$(./obj_dir/cpu_sim +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
